// File: rtl/cu_cfg.svh
// Sizes, buffer depths and thresholds of the edge data stage, included by the package and RTL
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

////////////////////////////////////////////////////////////
// Memory geometry
////////////////////////////////////////////////////////////

// Bytes per vertex datum
`define CU_DATA_SIZE_READ 4
`define CU_CACHELINE_BYTES 128
`define CU_ADDRESS_WIDTH 64
`define CU_VERTEX_WIDTH 32
`define CU_COMMAND_SIZE_WIDTH 12
`define CU_LINE_WORDS (`CU_CACHELINE_BYTES / `CU_DATA_SIZE_READ)
`define CU_OFFSET_WIDTH $clog2(`CU_LINE_WORDS)

////////////////////////////////////////////////////////////
// Buffering
////////////////////////////////////////////////////////////

`define CU_BUFFER_DEPTH 16
// Almost full once fewer free entries than this remain
`define CU_ALFULL_MARGIN 4

`endif

// File: rtl/cu_pkg.sv
// Shared types of the edge data stage, referenced by scoped name from RTL and testbench
`default_nettype none

`include "cu_cfg.svh"

package cu_pkg;

	////////////////////////////////////////////////////////////
	// Bus command encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		read_cl_s  = 2'b01,
		read_cl_na = 2'b10
	} command_kind;

	////////////////////////////////////////////////////////////
	// Jobs, commands and responses
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                          valid;
		logic [`CU_VERTEX_WIDTH-1:0]   dest;
	} edge_job;

	// Travels with the command and comes back with the response
	typedef struct packed {
		logic [`CU_OFFSET_WIDTH-1:0]   cacheline_offset;
		logic [`CU_VERTEX_WIDTH-1:0]   dest;
	} read_tag;

	typedef struct packed {
		logic                              valid;
		logic [`CU_ADDRESS_WIDTH-1:0]      address;
		logic [`CU_COMMAND_SIZE_WIDTH-1:0] size;
		command_kind                       command;
		read_tag                           tag;
	} read_command;

	// Word 0 of the line sits in bits [31:0]
	typedef struct packed {
		logic                              valid;
		read_tag                           tag;
		logic [`CU_CACHELINE_BYTES*8-1:0]  line;
	} read_response;

	typedef struct packed {
		logic                          valid;
		logic [`CU_VERTEX_WIDTH-1:0]   dest;
		logic [`CU_VERTEX_WIDTH-1:0]   value;
	} edge_data;

	////////////////////////////////////////////////////////////
	// Buffer status
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic valid;
		logic empty;
		logic full;
		logic alfull;
	} buffer_status;

endpackage

`default_nettype wire

// File: rtl/fifo.sv
// Synchronous first-word-fall-through FIFO, payload type set per instance by parameter
`default_nettype none

`include "cu_cfg.svh"

module fifo #(
	parameter type         payload_t = logic [31:0],
	parameter int unsigned depth     = `CU_BUFFER_DEPTH
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     full,
	output logic     alfull,
	output logic     empty,
	output logic     valid
);

	localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int unsigned cnt_w = $clog2(depth + 1);
	localparam logic [cnt_w-1:0] alfull_level = cnt_w'(depth - `CU_ALFULL_MARGIN);
	localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);

	payload_t         mem [depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Overflow and underflow are dropped here and flagged below
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Head shows without a read cycle
	assign data_out = mem[rd_ptr];

	assign empty  = (count == '0);
	assign full   = (count == cnt_w'(depth));
	assign alfull = (count > alfull_level);
	assign valid  = !empty;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_no_push_when_full: assert property (@(posedge clock) disable iff (~rstn) !(push && full))
		else $error("fifo push while full");

	a_no_pop_when_empty: assert property (@(posedge clock) disable iff (~rstn) !(pop && empty))
		else $error("fifo pop while empty");

endmodule

`default_nettype wire

// File: rtl/read_data_extract.sv
// Picks the addressed vertex word out of a returning cache line and forms edge data
`default_nettype none

`include "cu_cfg.svh"

module read_data_extract (
	input  logic                 clock,
	input  logic                 rstn,
	input  cu_pkg::read_response read_response_in,
	output cu_pkg::edge_data     edge_data_read
);

	logic [`CU_VERTEX_WIDTH-1:0] word_sel;
	logic                        valid_q;
	logic [`CU_VERTEX_WIDTH-1:0] dest_q;
	logic [`CU_VERTEX_WIDTH-1:0] value_q;

	////////////////////////////////////////////////////////////
	// Word select
	////////////////////////////////////////////////////////////

	// Offset counts 32-bit words from the low end of the line
	assign word_sel = read_response_in.line[
		read_response_in.tag.cacheline_offset * `CU_VERTEX_WIDTH +: `CU_VERTEX_WIDTH];

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= read_response_in.valid;
		end
	end

	// Payload qualified by valid_q
	always_ff @(posedge clock) begin
		if (read_response_in.valid) begin
			dest_q  <= read_response_in.tag.dest;
			value_q <= word_sel;
		end
	end

	assign edge_data_read = '{valid: valid_q, dest: dest_q, value: value_q};

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Tag must survive the round trip through memory
	a_known_offset: assert property (@(posedge clock) disable iff (~rstn)
		read_response_in.valid |-> !$isunknown(read_response_in.tag.cacheline_offset))
		else $error("read response with unknown cacheline offset");

	a_known_dest: assert property (@(posedge clock) disable iff (~rstn)
		read_response_in.valid |=> !$isunknown(edge_data_read.dest))
		else $error("edge data entry with unknown destination");

endmodule

`default_nettype wire

// File: rtl/edge_data_control.sv
// Edge data control that turns edge jobs into cache-line reads and buffers returned edge data
`default_nettype none

`include "cu_cfg.svh"

module edge_data_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled_in,
	input  logic [63:0]                  cu_configure,
	input  logic [`CU_ADDRESS_WIDTH-1:0] data_base,
	input  cu_pkg::edge_data             edge_data_read_in,
	input  cu_pkg::edge_job              edge_job,
	input  logic                         edge_data_request,
	input  cu_pkg::buffer_status         read_buffer_status,
	input  logic                         read_command_bus_grant,
	output logic                         edge_request,
	output logic                         read_command_bus_request,
	output cu_pkg::read_command          read_command_out,
	output cu_pkg::buffer_status         data_buffer_status,
	output cu_pkg::edge_data             edge_data
);

	logic                         enabled;
	logic                         enabled_cmd;
	logic [63:0]                  cu_configure_latched;
	cu_pkg::edge_job              edge_job_latched;
	cu_pkg::edge_data             edge_data_latched;
	logic                         edge_data_request_latched;
	logic                         grant_latched;
	cu_pkg::edge_job              job_head;
	cu_pkg::buffer_status         job_status;
	cu_pkg::read_command          command_latched;
	cu_pkg::read_command          command_head;
	cu_pkg::read_command          command_popped;
	cu_pkg::buffer_status         command_status;
	cu_pkg::edge_data             data_head;
	cu_pkg::buffer_status         data_status;
	logic                         job_pop;
	logic                         command_pop;
	logic                         data_pop;
	logic [`CU_ADDRESS_WIDTH-1:0] job_byte_offset;
	logic [`CU_ADDRESS_WIDTH-1:0] job_address;

	////////////////////////////////////////////////////////////
	// Enables and input latches
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled                   <= 1'b0;
			enabled_cmd               <= 1'b0;
			cu_configure_latched      <= '0;
			edge_job_latched          <= '0;
			edge_data_latched         <= '0;
			edge_data_request_latched <= 1'b0;
			grant_latched             <= 1'b0;
		end else begin
			enabled     <= enabled_in;
			enabled_cmd <= enabled && (|cu_configure_latched);
			if (enabled) begin
				edge_job_latched          <= edge_job;
				edge_data_latched         <= edge_data_read_in;
				edge_data_request_latched <= edge_data_request;
				grant_latched             <= read_command_bus_grant;
				// A zero word leaves the last configuration in place
				if (|cu_configure) begin
					cu_configure_latched <= cu_configure;
				end
			end else begin
				edge_job_latched.valid    <= 1'b0;
				edge_data_latched.valid   <= 1'b0;
				edge_data_request_latched <= 1'b0;
				grant_latched             <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read command generation
	////////////////////////////////////////////////////////////

	// Jobs leave only while the command buffer can take the one in flight
	assign job_pop = enabled_cmd && job_status.valid && !command_status.alfull;

	assign job_byte_offset = `CU_ADDRESS_WIDTH'(job_head.dest) << $clog2(`CU_DATA_SIZE_READ);
	assign job_address     = (data_base + job_byte_offset)
		& ~(`CU_ADDRESS_WIDTH'(`CU_CACHELINE_BYTES - 1));

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			command_latched <= '0;
		end else if (job_pop) begin
			command_latched.valid                <= 1'b1;
			command_latched.address              <= job_address;
			command_latched.size                 <= `CU_COMMAND_SIZE_WIDTH'(`CU_CACHELINE_BYTES);
			command_latched.tag.cacheline_offset <= job_head.dest[`CU_OFFSET_WIDTH-1:0];
			command_latched.tag.dest             <= job_head.dest;
			command_latched.command              <= cu_configure_latched[13]
				? cu_pkg::read_cl_s : cu_pkg::read_cl_na;
		end else begin
			command_latched.valid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Buffers
	////////////////////////////////////////////////////////////

	fifo #(.payload_t(cu_pkg::edge_job)) job_buffer (
		.clock(clock), .rstn(rstn),
		.push(edge_job_latched.valid), .data_in(edge_job_latched),
		.pop(job_pop), .data_out(job_head),
		.full(job_status.full), .alfull(job_status.alfull),
		.empty(job_status.empty), .valid(job_status.valid)
	);

	// Grants past the last command pop nothing
	assign command_pop = grant_latched && command_status.valid;

	fifo #(.payload_t(cu_pkg::read_command)) command_buffer (
		.clock(clock), .rstn(rstn),
		.push(command_latched.valid), .data_in(command_latched),
		.pop(command_pop), .data_out(command_head),
		.full(command_status.full), .alfull(command_status.alfull),
		.empty(command_status.empty), .valid(command_status.valid)
	);

	assign data_pop = edge_data_request_latched && data_status.valid;

	fifo #(.payload_t(cu_pkg::edge_data)) data_buffer (
		.clock(clock), .rstn(rstn),
		.push(edge_data_latched.valid), .data_in(edge_data_latched),
		.pop(data_pop), .data_out(data_head),
		.full(data_status.full), .alfull(data_status.alfull),
		.empty(data_status.empty), .valid(data_status.valid)
	);

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			command_popped           <= '0;
			read_command_out         <= '0;
			read_command_bus_request <= 1'b0;
			edge_request             <= 1'b0;
			edge_data                <= '0;
			data_buffer_status       <= '0;
			data_buffer_status.empty <= 1'b1;
		end else begin
			command_popped           <= command_head;
			command_popped.valid     <= command_pop;
			read_command_bus_request <= enabled_cmd && !read_buffer_status.alfull
				&& !command_status.empty;
			if (enabled) begin
				read_command_out   <= command_popped;
				edge_request       <= !job_status.alfull;
				edge_data          <= data_head;
				edge_data.valid    <= data_pop;
				data_buffer_status <= data_status;
			end else begin
				read_command_out.valid <= 1'b0;
				edge_request           <= 1'b0;
				edge_data.valid        <= 1'b0;
			end
		end
	end

	// Bus side keeps its grants within our request level
	a_grant_needs_request: assert property (@(posedge clock) disable iff (~rstn)
		read_command_bus_grant |-> read_command_bus_request)
		else $error("grant without pending read request");

	a_pop_needs_data: assert property (@(posedge clock) disable iff (~rstn)
		edge_data_request |-> data_buffer_status.valid)
		else $error("edge data pop on empty data buffer");

endmodule

`default_nettype wire

// File: rtl/cu_edge_data_unit.sv
// Edge data stage top level, wiring the line extractor into the edge data control
`default_nettype none

module cu_edge_data_unit (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  logic [63:0]          cu_configure,
	input  logic [63:0]          data_base,
	input  cu_pkg::edge_job      edge_job_in,
	input  logic                 read_command_bus_grant,
	input  cu_pkg::buffer_status read_buffer_status,
	input  cu_pkg::read_response read_response_in,
	input  logic                 edge_data_request,
	output logic                 edge_request,
	output logic                 read_command_bus_request,
	output cu_pkg::read_command  read_command_out,
	output cu_pkg::buffer_status data_buffer_status,
	output cu_pkg::edge_data     edge_data_out
);

	// Extracted word on its way into the data buffer
	cu_pkg::edge_data edge_data_read;

	////////////////////////////////////////////////////////////
	// Response path
	////////////////////////////////////////////////////////////

	read_data_extract read_data_extract_inst (
		.clock           (clock),
		.rstn            (rstn),
		.read_response_in(read_response_in),
		.edge_data_read  (edge_data_read)
	);

	////////////////////////////////////////////////////////////
	// Command path and buffers
	////////////////////////////////////////////////////////////

	edge_data_control edge_data_control_inst (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled_in              (enabled_in),
		.cu_configure            (cu_configure),
		.data_base               (data_base),
		.edge_data_read_in       (edge_data_read),
		.edge_job                (edge_job_in),
		.edge_data_request       (edge_data_request),
		.read_buffer_status      (read_buffer_status),
		.read_command_bus_grant  (read_command_bus_grant),
		.edge_request            (edge_request),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out        (read_command_out),
		.data_buffer_status      (data_buffer_status),
		.edge_data               (edge_data_out)
	);

endmodule

`default_nettype wire

// File: verification/cu_edge_data_unit_tb.sv
// Testbench for the edge data stage that drives table jobs and models the bus and memory
`default_nettype none

`include "cu_cfg.svh"

module cu_edge_data_unit_tb;

	typedef struct packed {
		logic [31:0] dest;
		logic [3:0]  grant_delay;
		logic        backpressure;
	} stim_entry;

	localparam int num_entries    = 24;
	localparam int timeout_cycles = num_entries * 60 + 200;
	localparam int max_held_jobs  = 2 * `CU_BUFFER_DEPTH;
	localparam int line_words     = `CU_CACHELINE_BYTES / 4;
	localparam logic [63:0] base_address = 64'h0000_0001_2345_6780;

	// Destination, grant delay, back-pressure flag
	stim_entry stim_table [num_entries] = '{
		'{32'h0000_0000, 4'd0, 1'b0}, '{32'h0000_0001, 4'd1, 1'b0},
		'{32'h0000_001f, 4'd0, 1'b0}, '{32'h0000_0020, 4'd2, 1'b1},
		'{32'h0000_0005, 4'd0, 1'b0}, '{32'h0000_0100, 4'd3, 1'b0},
		'{32'h0000_007f, 4'd1, 1'b0}, '{32'h0000_1234, 4'd0, 1'b0},
		'{32'hffff_ffff, 4'd4, 1'b0}, '{32'h8000_0000, 4'd0, 1'b1},
		'{32'h0000_0040, 4'd2, 1'b0}, '{32'h0000_0021, 4'd0, 1'b0},
		'{32'h0000_0055, 4'd1, 1'b0}, '{32'h0000_aaaa, 4'd0, 1'b0},
		'{32'h0000_0003, 4'd5, 1'b0}, '{32'h0000_001f, 4'd0, 1'b1},
		'{32'hdead_beef, 4'd2, 1'b0}, '{32'h0000_0010, 4'd0, 1'b0},
		'{32'h2000_0001, 4'd3, 1'b0}, '{32'h0000_0077, 4'd1, 1'b0},
		'{32'h0000_0fff, 4'd0, 1'b1}, '{32'h0000_0009, 4'd2, 1'b0},
		'{32'h0000_4242, 4'd0, 1'b0}, '{32'h0000_0060, 4'd4, 1'b0}
	};

	logic                 clock = 1'b0;
	logic                 rstn;
	logic                 enabled_in;
	logic [63:0]          cu_configure;
	logic [63:0]          data_base;
	cu_pkg::edge_job      edge_job_in;
	logic                 read_command_bus_grant;
	cu_pkg::buffer_status read_buffer_status;
	cu_pkg::read_response read_response_in;
	logic                 edge_data_request;
	logic                 edge_request;
	logic                 read_command_bus_request;
	cu_pkg::read_command  read_command_out;
	cu_pkg::buffer_status data_buffer_status;
	cu_pkg::edge_data     edge_data_out;

	integer              seed = 32'hd078;
	int                  cycle_count = 0;
	int                  cmd_count = 0;
	logic                hold_grants = 1'b0;
	cu_pkg::read_command exp_cmds [$];
	cu_pkg::read_command pending [$];
	cu_pkg::edge_data    exp_data [$];

	cu_edge_data_unit cu_edge_data_unit_inst (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in), .cu_configure(cu_configure),
		.data_base(data_base), .edge_job_in(edge_job_in),
		.read_command_bus_grant(read_command_bus_grant),
		.read_buffer_status(read_buffer_status), .read_response_in(read_response_in),
		.edge_data_request(edge_data_request), .edge_request(edge_request),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out(read_command_out), .data_buffer_status(data_buffer_status),
		.edge_data_out(edge_data_out)
	);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Expected values and compare tasks
	////////////////////////////////////////////////////////////

	function automatic cu_pkg::read_command expected_command(input logic [31:0] dest,
		input logic kind_s);
		cu_pkg::read_command cmd;
		cmd = '0;
		cmd.valid = 1'b1;
		cmd.address = ((base_address + 64'(dest) * 64'd4) / 64'd128) * 64'd128;
		cmd.size = 12'(`CU_CACHELINE_BYTES);
		cmd.command = kind_s ? cu_pkg::read_cl_s : cu_pkg::read_cl_na;
		cmd.tag.cacheline_offset = 5'(dest % 32);
		cmd.tag.dest = dest;
		return cmd;
	endfunction

	// Memory word rule of word address XOR a fixed pattern
	function automatic cu_pkg::edge_data expected_data(input logic [31:0] dest);
		cu_pkg::edge_data entry;
		entry.valid = 1'b1;
		entry.dest = dest;
		entry.value = 32'((base_address + 64'(dest) * 64'd4) >> 2) ^ 32'h5a5a_0000;
		return entry;
	endfunction

	function automatic logic [`CU_CACHELINE_BYTES*8-1:0] memory_line(input logic [63:0] address);
		logic [`CU_CACHELINE_BYTES*8-1:0] line;
		for (int i = 0; i < line_words; i++) begin
			line[i*32 +: 32] = 32'((address >> 2) + 64'(i)) ^ 32'h5a5a_0000;
		end
		return line;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_command(input string name, input cu_pkg::read_command actual,
		input cu_pkg::read_command expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s: got %h expected %h", name, actual, expected));
		end
	endtask

	task automatic check_edge_data(input string name, input cu_pkg::edge_data actual,
		input cu_pkg::edge_data expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s: got %h expected %h", name, actual, expected));
		end
	endtask

	task automatic check_status(input string name, input cu_pkg::buffer_status actual,
		input cu_pkg::buffer_status expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s: got %h expected %h", name, actual, expected));
		end
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s: got %h expected %h", name, actual, expected));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic send_job(input logic [31:0] dest, input logic kind_s);
		while (!edge_request) @(negedge clock);
		exp_cmds.push_back(expected_command(dest, kind_s));
		edge_job_in = '{valid: 1'b1, dest: dest};
		@(negedge clock);
		edge_job_in = '0;
	endtask

	task automatic wait_commands(input int count);
		while (cmd_count < count) @(negedge clock);
	endtask

	// One half of the table under one command kind
	task automatic run_half(input int first, input int last, input logic kind_s);
		cu_configure = kind_s ? 64'h0000_0000_0000_2001 : 64'h0000_0000_0000_0001;
		for (int i = first; i <= last; i++) begin
			if (stim_table[i].backpressure) begin
				read_buffer_status.alfull = 1'b1;
				send_job(stim_table[i].dest, kind_s);
				repeat (6) begin
					check_level("read_command_bus_request", read_command_bus_request, 1'b0);
					@(negedge clock);
				end
				read_buffer_status.alfull = 1'b0;
			end else begin
				send_job(stim_table[i].dest, kind_s);
			end
		end
		wait_commands(last + 1);
	endtask

	////////////////////////////////////////////////////////////
	// Bus and memory model
	////////////////////////////////////////////////////////////

	initial begin
		cu_pkg::read_command cmd;
		cu_pkg::read_command exp_cmd;
		int idx;
		int grant_wait;
		int resp_wait;
		read_command_bus_grant = 1'b0;
		read_response_in = '0;
		grant_wait = 0;
		resp_wait = 0;
		forever begin
			@(negedge clock);
			read_command_bus_grant = 1'b0;
			read_response_in = '0;
			if (rstn) begin
				if (read_command_out.valid) begin
					if (exp_cmds.size() == 0) begin
						fail_run("A read command appeared with no job outstanding");
					end else begin
						exp_cmd = exp_cmds.pop_front();
						check_command("read_command_out", read_command_out, exp_cmd);
						cmd_count++;
						pending.push_back(read_command_out);
					end
				end
				if (!hold_grants && read_command_bus_request) begin
					if (grant_wait >= int'(stim_table[cmd_count % num_entries].grant_delay)) begin
						read_command_bus_grant = 1'b1;
						grant_wait = 0;
					end else begin
						grant_wait++;
					end
				end
				// Responses return in a shuffled order
				if (resp_wait > 0) begin
					resp_wait--;
				end else if (pending.size() != 0) begin
					idx = int'($unsigned($random(seed)) % 32'(pending.size()));
					cmd = pending[idx];
					pending.delete(idx);
					read_response_in.valid = 1'b1;
					read_response_in.tag = cmd.tag;
					read_response_in.line = memory_line(cmd.address);
					exp_data.push_back(expected_data(cmd.tag.dest));
					resp_wait = int'($unsigned($random(seed)) % 32'd4);
				end
			end
		end
	end

	// Data consumer pops whenever the buffer reports data
	initial begin
		cu_pkg::edge_data exp_entry;
		edge_data_request = 1'b0;
		forever begin
			@(negedge clock);
			edge_data_request = rstn && data_buffer_status.valid;
			if (edge_data_out.valid) begin
				if (exp_data.size() == 0) begin
					fail_run("Edge data appeared with no response outstanding");
				end else begin
					exp_entry = exp_data.pop_front();
					check_edge_data("edge_data_out", edge_data_out, exp_entry);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			fail_run($sformatf("Run did not finish within %0d cycles", timeout_cycles));
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int held;
		rstn = 1'b0;
		enabled_in = 1'b0;
		cu_configure = '0;
		data_base = base_address;
		edge_job_in = '0;
		read_buffer_status = '0;
		held = 0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);

		// Idle outputs before any enable
		check_level("read_command_out.valid", read_command_out.valid, 1'b0);
		check_level("edge_data_out.valid", edge_data_out.valid, 1'b0);
		check_level("edge_request", edge_request, 1'b0);
		check_level("read_command_bus_request", read_command_bus_request, 1'b0);
		check_status("data_buffer_status", data_buffer_status, '{1'b0, 1'b1, 1'b0, 1'b0});

		// A job while disabled is dropped
		edge_job_in = '{valid: 1'b1, dest: 32'h0000_0055};
		@(negedge clock);
		edge_job_in = '0;
		repeat (6) begin
			@(negedge clock);
			check_level("read_command_bus_request", read_command_bus_request, 1'b0);
			check_level("read_command_out.valid", read_command_out.valid, 1'b0);
		end

		enabled_in = 1'b1;
		run_half(0, num_entries / 2 - 1, 1'b1);
		run_half(num_entries / 2, num_entries - 1, 1'b0);

		// Jobs pile up while grants are held off
		hold_grants = 1'b1;
		while (edge_request && held < max_held_jobs) begin
			send_job(stim_table[held % num_entries].dest ^ 32'h0001_0000, 1'b0);
			held++;
		end
		if (edge_request) begin
			fail_run($sformatf("edge_request still high after %0d jobs with grants held", held));
		end
		hold_grants = 1'b0;
		wait_commands(num_entries + held);

		while (exp_data.size() != 0 || pending.size() != 0) @(negedge clock);
		repeat (4) @(negedge clock);
		if (exp_cmds.size() != 0 || cmd_count != num_entries + held) begin
			fail_run($sformatf("Received %0d commands for %0d jobs", cmd_count,
				num_entries + held));
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/cu_pkg.sv
rtl/fifo.sv
rtl/read_data_extract.sv
rtl/edge_data_control.sv
rtl/cu_edge_data_unit.sv
verification/cu_edge_data_unit_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Compile the edge data stage with its testbench and run it under Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module cu_edge_data_unit_tb \
	-Mdir obj_dir

./obj_dir/Vcu_edge_data_unit_tb
